//--- Makefile
TOP = vfdTb

sim:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -o simv
	./obj_dir/simv > sim.log 2>&1 || echo "** FAIL **" >> sim.log
	cat sim.log
	! grep -F -q "** FAIL **" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

//--- hw/gcpGenerator.sv
// ============================
// GCP generator
// Gradient control pulses at the table
// bit positions during shifting
// ============================
`timescale 1ns/1ps

module gcpGenerator (
	input  logic           CLK,
	input  logic           arstN,
	input  logic           shiftEn,
	input  vfdPkg::bitIdxT bitIdx,
	input  logic           bitPhase,
	output logic           gcp
);
	import vfdPkg::*;

	logic inPulse; // Current bit inside a pulse window

	always_comb begin
		inPulse = 1'b0;
		for (int k = 0; k < GcpCount; k++) begin
			if (bitIdx >= bitIdxT'(GcpStarts[k]) &&
				bitIdx < bitIdxT'(GcpStarts[k] + GcpWidth))
				inPulse = 1'b1;
		end
	end

	// Set in phase 0, so gcp is high on the phase 1 cycle of the same bit
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN)
			gcp <= 1'b0;
		else
			gcp <= shiftEn && !bitPhase && inPulse;
	end

endmodule

//--- hw/gram.sv
// ============================
// Graphic RAM
// 3003 bytes, host write port and
// registered scan read port
// ============================
`timescale 1ns/1ps

module gram (
	input  logic             CLK,
	input  logic             wrEn,
	input  vfdPkg::gramAddrT wrAddr,
	input  vfdPkg::gramByteT wrData,
	input  logic             rdEn,
	input  vfdPkg::gramAddrT rdAddr,
	output vfdPkg::gramByteT rdData
);
	import vfdPkg::*;

	gramByteT mem [GramBytes]; // 39 rows of 77 bytes

	// Writes past the last byte are dropped
	always_ff @(posedge CLK) begin
		if (wrEn && wrAddr < gramAddrT'(GramBytes))
			mem[wrAddr] <= wrData;
	end

	always_ff @(posedge CLK) begin
		if (rdEn)
			rdData <= mem[rdAddr]; // Data one cycle after address
	end

endmodule

//--- hw/hostWritePort.sv
// ============================
// Host write port
// Four-phase req/ack slave, one RAM
// byte write per handshake
// ============================
`timescale 1ns/1ps

module hostWritePort (
	input  logic             CLK,
	input  logic             arstN,
	input  vfdPkg::gramAddrT hostAddr,
	input  vfdPkg::gramByteT hostData,
	input  logic             hostReq,
	output logic             hostAck,
	output logic             wrEn,
	output vfdPkg::gramAddrT wrAddr,
	output vfdPkg::gramByteT wrData
);
	import vfdPkg::*;

	logic start; // New request seen, ack still low

	assign start = hostReq && !hostAck;

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			hostAck <= 1'b0;
			wrEn    <= 1'b0;
		end else begin
			wrEn <= start; // Single cycle strobe
			if (start)
				hostAck <= 1'b1;
			else if (!hostReq && hostAck)
				hostAck <= 1'b0; // Return to idle
		end
	end

	// Capture address and byte with the request
	always_ff @(posedge CLK) begin
		if (start) begin
			wrAddr <= hostAddr;
			wrData <= hostData;
		end
	end

	// Host opens a new request only once ack is back low
	aReqIdle: assert property (@(posedge CLK) disable iff (!arstN)
		$rose(hostReq) |-> !hostAck);

endmodule

//--- hw/scanSequencer.sv
// ============================
// Scan sequencer
// Per-slot FSM and current grid number
// ============================
`timescale 1ns/1ps

module scanSequencer (
	input  logic            CLK,
	input  logic            arstN,
	input  vfdPkg::slotCntT slotCnt,
	output logic            blk,
	output logic            lat,
	output logic            shiftEn,
	output vfdPkg::gridT    grid
);
	import vfdPkg::*;

	seqStateT state;
	seqStateT stateNext;
	logic     slotLast; // Final cycle, next one is cycle 0

	assign slotLast = (slotCnt == slotCntT'(SlotCycles - 1));

	// Transitions fire one cycle early so state lines up with slotCnt
	always_comb begin
		stateNext = state;
		case (state)
			SeqBlank: begin
				if (slotCnt == slotCntT'(LatStart - 1))
					stateNext = SeqLatch;
				else if (slotCnt == slotCntT'(BlkEnd - 1))
					stateNext = SeqSettle; // Back from latch, blank ends
			end
			SeqLatch:  if (slotCnt == slotCntT'(LatEnd - 1)) stateNext = SeqBlank;
			SeqSettle: if (slotCnt == slotCntT'(ShiftStart - 1)) stateNext = SeqShift;
			SeqShift:  if (slotCnt == slotCntT'(ShiftEnd - 1)) stateNext = SeqRest;
			default:   if (slotLast) stateNext = SeqBlank;
		endcase
	end

	// Reset parks in rest at the last cycle, so slot 0 starts right after release
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			state <= SeqRest;
			grid  <= gridT'(GridCount); // Steps to grid 1 on the first wrap
		end else begin
			state <= stateNext;
			if (slotLast)
				grid <= (grid == gridT'(GridCount)) ? gridT'(1) : grid + gridT'(1);
		end
	end

	assign blk     = (state == SeqBlank) || (state == SeqLatch);
	assign lat     = (state == SeqLatch);
	assign shiftEn = (state == SeqShift);

	// Latch pulse sits inside the blank window, on its own cycle marks
	aLatInBlk: assert property (@(posedge CLK) disable iff (!arstN)
		lat |-> blk && slotCnt >= slotCntT'(LatStart) && slotCnt < slotCntT'(LatEnd));

endmodule

//--- hw/slotTimer.sv
// ============================
// Slot timer
// Cycle count over the slot, bit index
// and serial phase while shifting
// ============================
`timescale 1ns/1ps

module slotTimer (
	input  logic            CLK,
	input  logic            arstN,
	input  logic            shiftEn,
	output vfdPkg::slotCntT slotCnt,
	output vfdPkg::bitIdxT  bitIdx,
	output logic            bitPhase
);
	import vfdPkg::*;

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			slotCnt  <= slotCntT'(SlotCycles - 1); // Wraps to 0 on first edge
			bitIdx   <= '0;
			bitPhase <= 1'b0;
		end else begin
			slotCnt <= (slotCnt == slotCntT'(SlotCycles - 1)) ? '0 : slotCnt + slotCntT'(1);
			if (shiftEn) begin
				bitPhase <= ~bitPhase; // Half-rate toggle, also the serial clock
				if (bitPhase)
					bitIdx <= (bitIdx == bitIdxT'(SlotBits - 1)) ? '0 : bitIdx + bitIdxT'(1);
			end else begin
				bitIdx   <= '0;
				bitPhase <= 1'b0;
			end
		end
	end

	// Bit 287 is the last one, the index never wraps while shifting goes on
	aBitRange: assert property (@(posedge CLK) disable iff (!arstN)
		shiftEn && bitPhase && bitIdx == bitIdxT'(SlotBits - 1) |=> !shiftEn);

	// Sequencer drops shiftEn exactly after phase 1 of the last bit
	aShiftEnd: assert property (@(posedge CLK) disable iff (!arstN)
		$fell(shiftEn) |-> $past(bitPhase) && $past(bitIdx) == bitIdxT'(SlotBits - 1));

endmodule

//--- hw/triSerializer.sv
// ============================
// Tri-line serializer
// Pixel fetch, A F B E C D order with
// half masking, then grid select bits
// ============================
`timescale 1ns/1ps

module triSerializer (
	input  logic             CLK,
	input  logic             arstN,
	input  logic             shiftEn,
	input  vfdPkg::bitIdxT   bitIdx,
	input  logic             bitPhase,
	input  vfdPkg::gridT     grid,
	output logic             rdEn,
	output vfdPkg::gramAddrT rdAddr,
	input  vfdPkg::gramByteT rdData,
	output logic [2:0]       serOut,
	output logic             sck
);
	import vfdPkg::*;

	bitIdxT     nextIdx;  // Bit whose byte is fetched next
	logic       issue;    // Fetch slot
	logic       nextPix;
	logic       nextGrid;
	logic       nextHi;   // Upper pixel of the byte
	logic [1:0] byteOff;
	logic [2:0] pixSel;   // Position in A F B E C D
	gramAddrT   rowBase;  // 77 per row, no multiplier
	gramAddrT   colBase;
	gridT       pairIdx;  // Grids 1,2 share a column, so do 3,4
	bitIdxT     gridPos;
	grayT       hiPix;
	grayT       loPix;
	logic       pendPix;  // Info for the read in flight
	logic       pendHi;
	logic       pendKeep;
	logic       pendGrid;

	// Idle prefetches bit 0, shifting fetches bit b+1 during phase 1 of bit b
	assign nextIdx = shiftEn ? bitIdx + bitIdxT'(bitPhase) : '0;
	assign issue   = !shiftEn || bitPhase;
	assign nextPix = nextIdx < bitIdxT'(PixelBits);

	always_comb begin
		case (pixSel)
			3'd0:    {byteOff, nextHi} = {2'd0, 1'b1}; // A
			3'd1:    {byteOff, nextHi} = {2'd2, 1'b0}; // F
			3'd2:    {byteOff, nextHi} = {2'd0, 1'b0}; // B
			3'd3:    {byteOff, nextHi} = {2'd2, 1'b1}; // E
			3'd4:    {byteOff, nextHi} = {2'd1, 1'b1}; // C
			default: {byteOff, nextHi} = {2'd1, 1'b0}; // D
		endcase
	end

	assign pairIdx = (grid - gridT'(1)) >> 1;
	assign colBase = gramAddrT'({pairIdx, 1'b0}) + gramAddrT'(pairIdx); // x3
	assign rdAddr  = rowBase + colBase + gramAddrT'(byteOff);
	assign rdEn    = issue && nextPix; // No reads in the grid section

	// Grid section: lines high at grid-1 and grid
	assign gridPos  = nextIdx - bitIdxT'(PixelBits);
	assign nextGrid = !nextPix && ((gridPos == bitIdxT'(grid) - bitIdxT'(1)) ||
		(gridPos == bitIdxT'(grid)));

	// Row and pixel counters track nextIdx
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			pixSel  <= '0;
			rowBase <= '0;
		end else if (!shiftEn || (bitPhase && bitIdx == bitIdxT'(SlotBits - 1))) begin
			pixSel  <= '0;
			rowBase <= '0;
		end else if (!bitPhase) begin
			if (pixSel == 3'd5) begin
				pixSel  <= '0;
				rowBase <= rowBase + gramAddrT'(RowBytes); // Next row
			end else begin
				pixSel <= pixSel + 3'd1;
			end
		end
	end

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			pendPix  <= 1'b0;
			pendHi   <= 1'b0;
			pendKeep <= 1'b0;
			pendGrid <= 1'b0;
		end else if (issue) begin
			pendPix  <= nextPix;
			pendHi   <= nextHi;
			pendKeep <= pixSel[0] ^ grid[0]; // ABC on odd grids, DEF on even
			pendGrid <= nextGrid;
		end
	end

	assign hiPix = rdData[5:3];
	assign loPix = rdData[2:0];

	always_comb begin
		if (!shiftEn)
			serOut = 3'b000;
		else if (pendPix)
			serOut = pendKeep ? (pendHi ? hiPix : loPix) : 3'b000;
		else
			serOut = {3{pendGrid}};
	end

	assign sck = shiftEn && bitPhase; // Rises mid-bit

endmodule

//--- hw/vfdPkg.sv
// ============================
// VFD scan controller package
// Display geometry, slot timing marks,
// GCP pulse table and shared types
// ============================

package vfdPkg;

	// ============================
	// Shared types
	// ============================
	typedef logic [11:0] gramAddrT; // Graphic RAM byte address
	typedef logic [7:0]  gramByteT; // Two gray pixels, 00uuulll
	typedef logic [2:0]  grayT;     // One pixel, 8 levels
	typedef logic [5:0]  gridT;     // Grid number 1..52
	typedef logic [8:0]  bitIdxT;   // Serial bit within a slot
	typedef logic [9:0]  slotCntT;  // Cycle within a slot

	// Display geometry
	localparam int GridCount = 52;
	localparam int RowCount  = 39;
	localparam int RowBytes  = 77;
	localparam int GramBytes = RowCount * RowBytes; // 3003
	localparam int PixelBits = RowCount * 6;        // 234 pixel bits
	localparam int SlotBits  = 288;                 // Pixels then 54 grid bits

	// Slot timing in CLK cycles
	localparam int SlotCycles = 1024;
	localparam int BlkEnd     = 5;  // blk high 0..4
	localparam int LatStart   = 1;  // lat high 1..3
	localparam int LatEnd     = 4;
	localparam int ShiftStart = 124;
	localparam int ShiftEnd   = ShiftStart + 2 * SlotBits; // Two cycles per bit

	// Gradient control pulse table, in bit times
	localparam int GcpWidth = 3;
	localparam int GcpCount = 6;
	localparam int GcpStarts [GcpCount] = '{72, 144, 192, 216, 240, 256};

	// Slot phases
	typedef enum logic [2:0] {
		SeqBlank,  // blk only
		SeqLatch,  // blk and lat
		SeqSettle, // Grid driver settling
		SeqShift,  // 288 bits out
		SeqRest    // Idle to slot end
	} seqStateT;

endpackage

//--- hw/vfdTop.sv
// ============================
// VFD scan controller top
// Host byte port, graphic RAM and the
// tri-line serial scan of 52 grids
// ============================
`timescale 1ns/1ps

module vfdTop (
	input  logic             CLK,
	input  logic             arstN,
	input  vfdPkg::gramAddrT hostAddr,
	input  vfdPkg::gramByteT hostData,
	input  logic             hostReq,
	output logic             hostAck,
	output logic [2:0]       serOut,
	output logic             sck,
	output logic             blk,
	output logic             lat,
	output logic             gcp
);
	import vfdPkg::*;

	// Scan control
	slotCntT  slotCnt;
	bitIdxT   bitIdx;
	logic     bitPhase;
	logic     shiftEn;
	gridT     grid;

	// RAM ports
	logic     wrEn;
	gramAddrT wrAddr;
	gramByteT wrData;
	logic     rdEn;
	gramAddrT rdAddr;
	gramByteT rdData;

	slotTimer uTimer (.CLK, .arstN, .shiftEn, .slotCnt, .bitIdx, .bitPhase);

	scanSequencer uSeq (.CLK, .arstN, .slotCnt, .blk, .lat, .shiftEn, .grid);

	hostWritePort uHost (
		.CLK, .arstN, .hostAddr, .hostData, .hostReq, .hostAck,
		.wrEn, .wrAddr, .wrData
	);

	gram uGram (.CLK, .wrEn, .wrAddr, .wrData, .rdEn, .rdAddr, .rdData);

	triSerializer uSer (
		.CLK, .arstN, .shiftEn, .bitIdx, .bitPhase, .grid,
		.rdEn, .rdAddr, .rdData, .serOut, .sck
	);

	gcpGenerator uGcp (.CLK, .arstN, .shiftEn, .bitIdx, .bitPhase, .gcp);

endmodule

//--- tb.f
hw/vfdPkg.sv
hw/gram.sv
hw/hostWritePort.sv
hw/slotTimer.sv
hw/scanSequencer.sv
hw/triSerializer.sv
hw/gcpGenerator.sv
hw/vfdTop.sv
tb/vfdChecker.sv
tb/vfdTb.sv

//--- tb/vfdChecker.sv
// ============================
// VFD scan checker
// RAM model from host writes, slot timing,
// serial frame and GCP comparison
// ============================
`timescale 1ns/1ps

module vfdChecker (
	input  logic             CLK,
	input  logic             arstN,
	input  vfdPkg::gramAddrT hostAddr,
	input  vfdPkg::gramByteT hostData,
	input  logic             hostReq,
	input  logic             hostAck,
	input  logic [2:0]       serOut,
	input  logic             sck,
	input  logic             blk,
	input  logic             lat,
	input  logic             gcp,
	output int               slotsDone,
	output int               writesSeen,
	output int               valueErrs,
	output int               protoErrs
);
	import vfdPkg::*;

	// Display order A F B E C D
	localparam int ByteOff   [6] = '{0, 2, 0, 2, 1, 1};
	localparam bit UpperHalf [6] = '{1, 0, 0, 1, 1, 0};

	gramByteT ramModel [GramBytes];
	bit       ramKnown [GramBytes]; // Never-written bytes are not predicted
	gramAddrT pendAddr;
	gramByteT pendData;
	logic     prevReq;
	logic     prevAck;
	int       cyc;      // Cycle since the first slot began, -1 before it
	int       sckCount; // Bits seen in the current slot

	// Bit 3 set when the lines can be predicted, bits 2..0 are the lines
	function automatic logic [3:0] expectLines(input int g, input int b);
		int         r;
		int         s;
		int         addr;
		gramByteT   v;
		logic [2:0] pix;
		if (b >= PixelBits)
			return ((b - PixelBits == g - 1) || (b - PixelBits == g)) ? 4'hf : 4'h8;
		r = b / 6;
		s = b % 6;
		if ((s % 2 == 0) != (g % 2 == 1))
			return 4'h8; // ABC dark on even grids, DEF on odd
		addr = RowBytes * r + 3 * ((g - 1) / 2) + ByteOff[s];
		if (addr >= GramBytes || !ramKnown[addr])
			return 4'h0; // Last column pair runs past the RAM end
		v   = ramModel[addr];
		pix = UpperHalf[s] ? v[5:3] : v[2:0];
		return {1'b1, pix};
	endfunction

	function automatic logic gcpWindow(input int b);
		for (int k = 0; k < GcpCount; k++) begin
			if (b >= GcpStarts[k] && b < GcpStarts[k] + GcpWidth)
				return 1'b1;
		end
		return 1'b0;
	endfunction

	task automatic compareValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual, input int slot, input int where);
		if (actual !== expected) begin
			valueErrs++;
			$display("[ERROR] %s slot %0d at %0d: expected 0x%0h, got 0x%0h",
				name, slot, where, expected, actual);
		end
	endtask

	task automatic protocolError(input string what);
		protoErrs++;
		$display("Handshake problem at %0t ns: %s", $time, what);
	endtask

	always @(posedge CLK or negedge arstN) begin
		int         pos;
		int         slot;
		int         g;
		logic       phase1;
		logic [3:0] lines;
		if (!arstN) begin
			cyc      = -1;
			sckCount = 0;
			prevReq  = 1'b0;
			prevAck  = 1'b0;
		end else begin
			// ============================
			// Host port, four phases
			// ============================
			if (hostReq && !prevReq) begin
				if (hostAck)
					protocolError("new request while hostAck is still high");
				pendAddr = hostAddr;
				pendData = hostData;
			end
			if (hostAck && !prevAck) begin
				if (!prevReq) // Request seen on the edge that raised ack
					protocolError("hostAck rose without a held request");
				if (int'(pendAddr) < GramBytes) begin
					ramModel[pendAddr] = pendData; // Byte lands with the ack
					ramKnown[pendAddr] = 1'b1;
				end
			end
			if (!hostAck && prevAck) begin
				if (hostReq)
					protocolError("hostAck fell while hostReq was high");
				writesSeen++;
			end

			// ============================
			// Scan slot
			// ============================
			if (cyc < 0) begin
				compareValue("outputs after reset", 32'h0,
					32'({blk, lat, sck, gcp, hostAck, serOut}), 0, 0);
			end else begin
				pos    = cyc % SlotCycles;
				slot   = cyc / SlotCycles;
				g      = slot % GridCount + 1;
				phase1 = pos >= ShiftStart && pos < ShiftStart + 2 * SlotBits &&
					(pos - ShiftStart) % 2 == 1; // Second half of each bit
				compareValue("blk", 32'(pos < BlkEnd), 32'(blk), slot, pos);
				compareValue("lat", 32'(pos >= LatStart && pos < LatEnd), 32'(lat), slot, pos);
				compareValue("sck", 32'(phase1), 32'(sck), slot, pos);
				compareValue("gcp", 32'(phase1 && gcpWindow((pos - ShiftStart) / 2)),
					32'(gcp), slot, pos);
				if (sck) begin
					if (sckCount < SlotBits) begin
						lines = expectLines(g, sckCount);
						if (lines[3])
							compareValue("serOut", 32'(lines[2:0]), 32'(serOut), slot, sckCount);
					end
					sckCount++;
				end
				if (pos == SlotCycles - 1) begin
					compareValue("sck pulse count", 32'(SlotBits), 32'(sckCount), slot, pos);
					sckCount = 0;
					slotsDone++;
				end
			end
			cyc++;
			prevReq = hostReq;
			prevAck = hostAck;
		end
	end

endmodule

//--- tb/vfdStim.txt
// Columns: tag (1 hex), RAM address (3 hex), byte (2 hex)
// Tag 1 is a host write, tag 2 gives the number of slots to check in the low bits
10003d
10011a
10022c
1003f7
10b935
1b6e0e
1bb821
1bba3f
1c0055
100012
200036

//--- tb/vfdTb.sv
// ============================
// VFD scan controller testbench
// Host writes from the stim file, then
// slot-by-slot checking and a watchdog
// ============================
`timescale 1ns/1ps

module vfdTb;
	import vfdPkg::*;

	localparam string StimPath  = "tb/vfdStim.txt";
	localparam int    StimDepth = 64;

	logic       CLK;
	logic       arstN;
	gramAddrT   hostAddr;
	gramByteT   hostData;
	logic       hostReq;
	logic       hostAck;
	logic [2:0] serOut;
	logic       sck;
	logic       blk;
	logic       lat;
	logic       gcp;

	logic [23:0] stimMem [StimDepth]; // tag, address, byte
	gramAddrT    wrAddrQ [$];
	gramByteT    wrDataQ [$];
	int          slotsWanted;
	int          limitCycles;
	int          tbErrs;
	int          slotsDone;
	int          writesSeen;
	int          valueErrs;
	int          protoErrs;

	always #50 CLK = ~CLK; // 100 ns period

	vfdTop DUT (
		.CLK, .arstN, .hostAddr, .hostData, .hostReq, .hostAck,
		.serOut, .sck, .blk, .lat, .gcp
	);

	vfdChecker uCheck (
		.CLK, .arstN, .hostAddr, .hostData, .hostReq, .hostAck,
		.serOut, .sck, .blk, .lat, .gcp,
		.slotsDone, .writesSeen, .valueErrs, .protoErrs
	);

	task automatic loadStim();
		logic [23:0] rec;
		for (int i = 0; i < StimDepth; i++)
			stimMem[i] = '0;
		$readmemh(StimPath, stimMem);
		for (int i = 0; i < StimDepth; i++) begin
			rec = stimMem[i];
			if (rec[23:20] == 4'h1) begin
				wrAddrQ.push_back(rec[19:8]);
				wrDataQ.push_back(rec[7:0]);
			end else if (rec[23:20] == 4'h2) begin
				slotsWanted = int'(rec[19:0]); // Slot count ends the records
				return;
			end
		end
		tbErrs++;
		$display("Stim file holds no slot count record");
	endtask

	// One four-phase handshake, everything moves on the falling edge
	task automatic hostWrite(input gramAddrT addr, input gramByteT data);
		@(negedge CLK);
		hostAddr = addr;
		hostData = data;
		hostReq  = 1'b1;
		do
			@(negedge CLK);
		while (!hostAck);
		hostReq = 1'b0;
		do
			@(negedge CLK);
		while (hostAck); // Ack low again, port idle
	endtask

	initial begin
		CLK         = 1'b0;
		arstN       = 1'b0;
		hostAddr    = '0;
		hostData    = '0;
		hostReq     = 1'b0;
		tbErrs      = 0;
		slotsWanted = 0;
		limitCycles = 0;
		loadStim();
		limitCycles = wrAddrQ.size() * 10 + (slotsWanted + 1) * SlotCycles + 100;
		repeat (16) @(negedge CLK);
		arstN = 1'b1;
		foreach (wrAddrQ[i])
			hostWrite(wrAddrQ[i], wrDataQ[i]);
		while (slotsDone < slotsWanted)
			@(negedge CLK);
		if (writesSeen != wrAddrQ.size()) begin
			tbErrs++;
			$display("Only %0d of %0d host writes finished the handshake",
				writesSeen, wrAddrQ.size());
		end
		$display("Slots %0d, writes %0d, value errors %0d, handshake errors %0d, tb errors %0d",
			slotsDone, writesSeen, valueErrs, protoErrs, tbErrs);
		if (valueErrs + protoErrs + tbErrs == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	// Watchdog, reset time added on top of the test length
	initial begin
		wait (limitCycles > 0);
		repeat (limitCycles + 16) @(posedge CLK);
		$display("Timeout: scan still running after %0d cycles, %0d of %0d slots checked",
			limitCycles, slotsDone, slotsWanted);
		$display("** FAIL **");
		$finish;
	end

endmodule
